// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = corr_tb
FLIST     = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/corr_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_macros.svh"

module corr_apb_regs import corr_pkg::*; (
   input  wire logic                   clk_x,          // correlator clock
   input  wire logic                   sw_d,           // async reset
   input  wire apb_req_t               apb_req_i,
   output apb_rsp_t                    apb_rsp_o,
   output corr_cfg_t                   cfg_o,
   input  wire logic                   swap_i,         // block finished
   input  wire logic [`CORR_ACC_W-1:0] vis_i,          // selected visibility
   input  wire logic                   bank_i,         // frozen bank index
   output logic      [2:0]             vis_sel_o,
   output logic                        irq_o           // block ready
);

   reg_addr_e               addr;
   logic                    access;       // apb access phase
   logic                    hit;          // address is mapped
   logic                    ro;           // read-only register
   logic                    wr_ok;
   logic                    rd_stat;      // status read, clears flags
   logic [31:0]             rdata;
   logic [`CORR_ADDR_W-1:0] vis_off;
   corr_cfg_t               cfg_q;
   logic                    ready_q;
   logic                    ovr_q;        // block lost before status read

   assign addr    = reg_addr_e'(apb_req_i.paddr);
   assign access  = apb_req_i.psel & apb_req_i.penable;
   assign wr_ok   = access & apb_req_i.pwrite & hit & ~ro;
   assign rd_stat = access & ~apb_req_i.pwrite & (addr == REG_STATUS);

   // -------------------------------------------------------------------------
   // address decode and read mux
   // -------------------------------------------------------------------------
   always_comb begin
      hit   = 1'b1;
      ro    = 1'b0;
      rdata = '0;
      case (addr)
         REG_CTRL:   rdata[0] = cfg_q.enable;
         REG_BCOUNT: rdata[`CORR_CNT_W-1:0] = cfg_q.bcount;
         REG_STATUS: begin
            rdata[1:0] = {ovr_q, ready_q};
            ro         = 1'b1;
         end
         REG_BANK: begin
            rdata[0] = bank_i;
            ro       = 1'b1;
         end
         REG_VIS0, REG_VIS1, REG_VIS2, REG_VIS3, REG_VIS4, REG_VIS5: begin
            rdata[`CORR_ACC_W-1:0] = vis_i;     // straight from frozen bank
            ro                     = 1'b1;
         end
         default: hit = 1'b0;
      endcase
   end

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = access & (~hit | (apb_req_i.pwrite & ro));

   // word offset from vis0 picks the pair
   assign vis_off   = apb_req_i.paddr - REG_VIS0;
   assign vis_sel_o = vis_off[4:2];

   // -------------------------------------------------------------------------
   // control and status
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         cfg_q   <= '0;
         ready_q <= 1'b0;
         ovr_q   <= 1'b0;
      end else begin
         if (wr_ok && addr == REG_CTRL) begin
            cfg_q.enable <= apb_req_i.pwdata[0];
         end
         if (wr_ok && addr == REG_BCOUNT) begin
            cfg_q.bcount <= apb_req_i.pwdata[`CORR_CNT_W-1:0];
         end
         if (swap_i) begin
            ready_q <= 1'b1;
            ovr_q   <= (ready_q | ovr_q) & ~rd_stat;  // unread block overwritten
         end else if (rd_stat) begin
            ready_q <= 1'b0;              // clear at end of access
            ovr_q   <= 1'b0;
         end
      end
   end

   assign cfg_o = cfg_q;
   assign irq_o = ready_q;

   // apb setup phase always precedes the access phase
   a_apb_setup: assert property (@(posedge clk_x) disable iff (sw_d)
      $rose(apb_req_i.penable) |-> apb_req_i.psel);

endmodule

`default_nettype wire

// ==== hw/corr_bank_switch.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_macros.svh"

module corr_bank_switch import corr_pkg::*; (
   input  wire logic      clk_x,          // correlator clock
   input  wire logic      sw_d,           // async reset
   input  wire corr_cfg_t cfg_i,          // enable and block length
   input  wire logic      strobe_i,       // new sample vector
   output logic           swap_o          // one-cycle bank swap
);

   localparam int FL_W = $clog2(`CORR_FLUSH + 1);

   sw_state_e              state_q;
   logic [`CORR_CNT_W-1:0] count_q;       // strobes seen this block
   logic [FL_W-1:0]        flush_q;       // cycles since the wrap strobe
   logic                   wrap;

   // == in normal use, >= also ends a block whose bcount was lowered mid-way
   assign wrap   = count_q >= cfg_i.bcount;
   // last flush cycle, final agreement is in the active bank by now
   assign swap_o = (state_q == SW_FLUSH) && (flush_q == FL_W'(`CORR_FLUSH - 1));

   // -------------------------------------------------------------------------
   // block counter and flush sequencing
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         state_q <= SW_OFF;
         count_q <= '0;
         flush_q <= '0;
      end else if (!cfg_i.enable) begin
         state_q <= SW_OFF;               // partial block is dropped
         count_q <= '0;
         flush_q <= '0;
      end else begin
         case (state_q)
            SW_OFF, SW_RUN: begin
               state_q <= SW_RUN;         // first enabled strobe already counts
               if (strobe_i) begin
                  if (wrap) begin
                     count_q <= '0;
                     flush_q <= '0;
                     state_q <= SW_FLUSH;
                  end else begin
                     count_q <= count_q + 1'b1;
                  end
               end
            end
            SW_FLUSH: begin
               if (swap_o) begin
                  state_q <= SW_RUN;
               end else begin
                  flush_q <= flush_q + 1'b1;
               end
            end
            default: begin
               state_q <= SW_OFF;
            end
         endcase
      end
   end

   // swap is a single pulse per block
   a_swap_pulse: assert property (@(posedge clk_x) disable iff (sw_d)
      swap_o |=> !swap_o);

   // strobe spacing keeps the flush clear of the next sample
   a_strobe_gap: assert property (@(posedge clk_x) disable iff (sw_d)
      strobe_i |=> !strobe_i [*3]);

endmodule

`default_nettype wire

// ==== hw/corr_macros.svh ====
`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// array geometry
`define CORR_NANT   4
// pairs of antennas, nant*(nant-1)/2
`define CORR_NPAIR  6

// block counter, holds block length minus one
`define CORR_CNT_W  10
// per-pair visibility accumulator
`define CORR_ACC_W  16

// apb byte address width, one 32-bit word per register
`define CORR_ADDR_W 6

// cycles from the last strobe of a block to the bank swap
`define CORR_FLUSH  2

`endif

// ==== hw/corr_pkg.sv ====
`default_nettype none
`include "corr_macros.svh"

package corr_pkg;

   // -------------------------------------------------------------------------
   // host bus
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic                    psel;      // slave selected
      logic                    penable;   // access phase
      logic                    pwrite;    // 1 = write
      logic [`CORR_ADDR_W-1:0] paddr;     // byte address
      logic [31:0]             pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;                // tied high, no wait states
      logic        pslverr;               // bad address or ro write
   } apb_rsp_t;

   // -------------------------------------------------------------------------
   // correlator control
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic                   enable;     // run the correlator
      logic [`CORR_CNT_W-1:0] bcount;     // samples per block minus one
   } corr_cfg_t;

   // register map, byte addresses
   typedef enum logic [`CORR_ADDR_W-1:0] {
      REG_CTRL   = 6'h00,                 // bit 0 enable
      REG_BCOUNT = 6'h04,
      REG_STATUS = 6'h08,                 // bit 0 ready, bit 1 overrun, clear on read
      REG_BANK   = 6'h0C,                 // frozen bank index
      REG_VIS0   = 6'h10,
      REG_VIS1   = 6'h14,
      REG_VIS2   = 6'h18,
      REG_VIS3   = 6'h1C,
      REG_VIS4   = 6'h20,
      REG_VIS5   = 6'h24
   } reg_addr_e;

   // bank switch fsm
   typedef enum logic [1:0] {
      SW_OFF,                             // disabled, counter parked
      SW_RUN,                             // counting strobes
      SW_FLUSH                            // waiting for pipeline to drain
   } sw_state_e;

endpackage

`default_nettype wire

// ==== hw/corr_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_macros.svh"

module corr_top import corr_pkg::*; (
   input  wire logic                  clk_x,           // correlator clock
   input  wire logic                  sw_d,            // async reset
   input  wire logic                  strobe_i,        // sample strobe
   input  wire logic [`CORR_NANT-1:0] sample_i,        // one bit per antenna
   input  wire apb_req_t              apb_req_i,
   output apb_rsp_t                   apb_rsp_o,
   output logic                       irq_o            // visibilities ready
);

   corr_cfg_t              cfg;
   logic [`CORR_NPAIR-1:0] agree;
   logic                   agree_valid;
   logic                   swap;
   logic [`CORR_ACC_W-1:0] vis;
   logic                   bank;
   logic [2:0]             vis_sel;

   // -------------------------------------------------------------------------
   // host side
   // -------------------------------------------------------------------------
   corr_apb_regs u_regs (
      .clk_x     (clk_x),
      .sw_d      (sw_d),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .cfg_o     (cfg),
      .swap_i    (swap),
      .vis_i     (vis),
      .bank_i    (bank),
      .vis_sel_o (vis_sel),
      .irq_o     (irq_o)
   );

   // -------------------------------------------------------------------------
   // correlator datapath
   // -------------------------------------------------------------------------
   corr_bank_switch u_switch (
      .clk_x    (clk_x),
      .sw_d     (sw_d),
      .cfg_i    (cfg),
      .strobe_i (strobe_i),
      .swap_o   (swap)
   );

   corr_xcorr u_xcorr (
      .clk_x         (clk_x),
      .sw_d          (sw_d),
      .enable_i      (cfg.enable),
      .strobe_i      (strobe_i),
      .sample_i      (sample_i),
      .agree_o       (agree),
      .agree_valid_o (agree_valid)
   );

   corr_vis_banks u_banks (
      .clk_x         (clk_x),
      .sw_d          (sw_d),
      .enable_i      (cfg.enable),
      .agree_i       (agree),
      .agree_valid_i (agree_valid),
      .swap_i        (swap),
      .vis_sel_i     (vis_sel),
      .vis_o         (vis),
      .bank_o        (bank)
   );

endmodule

`default_nettype wire

// ==== hw/corr_vis_banks.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_macros.svh"

module corr_vis_banks (
   input  wire logic                   clk_x,          // correlator clock
   input  wire logic                   sw_d,           // async reset
   input  wire logic                   enable_i,
   input  wire logic [`CORR_NPAIR-1:0] agree_i,        // per-pair agreement
   input  wire logic                   agree_valid_i,
   input  wire logic                   swap_i,         // end of block
   input  wire logic [2:0]             vis_sel_i,      // pair to read out
   output logic      [`CORR_ACC_W-1:0] vis_o,          // frozen visibility
   output logic                        bank_o          // frozen bank index
);

   logic [`CORR_ACC_W-1:0] acc_q [2][`CORR_NPAIR];   // two visibility banks
   logic                   bank_q;                   // frozen bank
   logic                   act;                      // bank being built up

   assign act = ~bank_q;

   // -------------------------------------------------------------------------
   // accumulate into the active bank, swap at block end
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         bank_q <= 1'b0;
         for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < `CORR_NPAIR; p++) begin
               acc_q[b][p] <= '0;
            end
         end
      end else if (swap_i) begin
         bank_q <= ~bank_q;               // active block freezes
         for (int p = 0; p < `CORR_NPAIR; p++) begin
            acc_q[bank_q][p] <= '0;       // old frozen bank starts fresh
         end
      end else if (!enable_i) begin
         for (int p = 0; p < `CORR_NPAIR; p++) begin
            acc_q[act][p] <= '0;          // idle, keep active bank clear
         end
      end else if (agree_valid_i) begin
         for (int p = 0; p < `CORR_NPAIR; p++) begin
            acc_q[act][p] <= acc_q[act][p] + `CORR_ACC_W'(agree_i[p]);
         end
      end
   end

   // -------------------------------------------------------------------------
   // readout from the frozen bank
   // -------------------------------------------------------------------------
   always_comb begin
      if (vis_sel_i < `CORR_NPAIR) begin
         vis_o = acc_q[bank_q][vis_sel_i];
      end else begin
         vis_o = '0;                      // no such pair
      end
   end

   assign bank_o = bank_q;

   // swap comes CORR_FLUSH cycles after the last strobe, clear of any agreement
   a_no_overlap: assert property (@(posedge clk_x) disable iff (sw_d)
      !(agree_valid_i && swap_i));

endmodule

`default_nettype wire

// ==== hw/corr_xcorr.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_macros.svh"

module corr_xcorr (
   input  wire logic                   clk_x,          // correlator clock
   input  wire logic                   sw_d,           // async reset
   input  wire logic                   enable_i,
   input  wire logic                   strobe_i,       // sample_i is valid
   input  wire logic [`CORR_NANT-1:0]  sample_i,       // one bit per antenna
   output logic      [`CORR_NPAIR-1:0] agree_o,        // 1 = pair bits equal
   output logic                        agree_valid_o
);

   logic [`CORR_NANT-1:0] smp_q;          // captured sample vector
   logic                  valid_q;

   // -------------------------------------------------------------------------
   // sample capture
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= enable_i & strobe_i;  // one cycle after the strobe
      end
   end

   always_ff @(posedge clk_x) begin
      if (enable_i && strobe_i) begin
         smp_q <= sample_i;
      end
   end

   // -------------------------------------------------------------------------
   // one-bit correlation, xnor per pair
   // -------------------------------------------------------------------------
   // pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   always_comb begin
      int p;
      p = 0;
      agree_o = '0;
      for (int a = 0; a < `CORR_NANT; a++) begin
         for (int b = a + 1; b < `CORR_NANT; b++) begin
            agree_o[p] = ~(smp_q[a] ^ smp_q[b]);  // same sign
            p = p + 1;
         end
      end
   end

   assign agree_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== verif/corr_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_macros.svh"

module corr_tb import corr_pkg::*; ();

   // 8 blocks of up to 64 strobes 7 cycles apart plus register traffic, about x4
   localparam int MAX_CYCLES = 20000;

   logic                  clk_x = 1'b0;
   logic                  sw_d;
   logic                  strobe_i;
   logic [`CORR_NANT-1:0] sample_i;
   apb_req_t              apb_req;
   apb_rsp_t              apb_rsp;
   logic                  irq;
   int                    cycles = 0;

   // reference model
   int   pair_a [`CORR_NPAIR] = '{0, 0, 0, 1, 1, 2};   // first antenna of pair
   int   pair_b [`CORR_NPAIR] = '{1, 2, 3, 2, 3, 3};   // second antenna of pair
   int   acc    [`CORR_NPAIR];                        // block in progress
   int   frozen [`CORR_NPAIR];                        // last finished block
   logic exp_bank;
   logic exp_ready;
   logic exp_ovr;

   corr_top uut (
      .clk_x     (clk_x),
      .sw_d      (sw_d),
      .strobe_i  (strobe_i),
      .sample_i  (sample_i),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp),
      .irq_o     (irq)
   );

   always #2 clk_x = ~clk_x;              // 4 ns period

   always @(posedge clk_x) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   // -------------------------------------------------------------------------
   // checks and bus access
   // -------------------------------------------------------------------------
   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED time %0t signal %s expected 0x%0h actual 0x%0h",
                  $time, name, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic apb_xfer(input logic wr, input logic [`CORR_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      @(posedge clk_x);
      #1;
      apb_req.psel    = 1'b1;             // setup phase
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk_x);
      #1;
      apb_req.penable = 1'b1;             // access phase
      #1;
      rdata = apb_rsp.prdata;             // no wait states
      err   = apb_rsp.pslverr;
      check_val("pready", 32'h1, 32'(apb_rsp.pready));
      @(posedge clk_x);
      #1;
      apb_req = '0;                       // back to idle
   endtask

   task automatic apb_write(input logic [`CORR_ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, data, rd, err);
      check_val("pslverr", 32'(exp_err), 32'(err));
   endtask

   task automatic apb_read(input logic [`CORR_ADDR_W-1:0] addr, input string name,
                           input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, addr, 32'h0, rd, err);
      check_val("pslverr", 32'h0, 32'(err));
      check_val(name, exp, rd);
   endtask

   task automatic check_vis();
      for (int p = 0; p < `CORR_NPAIR; p++) begin
         apb_read(`CORR_ADDR_W'(int'(REG_VIS0) + 4 * p), $sformatf("vis%0d", p),
                  32'(frozen[p]));
      end
   endtask

   // status clears on read and irq drops once the access ends
   task automatic check_status();
      apb_read(REG_STATUS, "status", {30'h0, exp_ovr, exp_ready});
      exp_ready = 1'b0;
      exp_ovr   = 1'b0;
      check_val("irq_o", 32'h0, 32'(irq));
   endtask

   // -------------------------------------------------------------------------
   // sample stimulus and model
   // -------------------------------------------------------------------------
   task automatic send_strobe(input logic [`CORR_NANT-1:0] smp, input logic count);
      int gap;
      gap = 4 + int'($urandom % 4);       // 4..7 cycles strobe to strobe
      @(posedge clk_x);
      #1;
      strobe_i = 1'b1;
      sample_i = smp;
      @(posedge clk_x);
      #1;
      strobe_i = 1'b0;
      repeat (gap - 2) @(posedge clk_x);
      if (count) begin
         for (int p = 0; p < `CORR_NPAIR; p++) begin
            if (smp[pair_a[p]] == smp[pair_b[p]]) begin
               acc[p] = acc[p] + 1;       // signs agree
            end
         end
      end
   endtask

   task automatic model_swap();
      exp_ovr   = exp_ovr | exp_ready;    // unread block lost
      exp_ready = 1'b1;
      exp_bank  = ~exp_bank;
      for (int p = 0; p < `CORR_NPAIR; p++) begin
         frozen[p] = acc[p];
         acc[p]    = 0;
      end
   endtask

   task automatic run_block(input int len);
      apb_write(REG_BCOUNT, 32'(len - 1), 1'b0);
      for (int i = 0; i < len; i++) begin
         send_strobe(`CORR_NANT'($urandom), 1'b1);
      end
      model_swap();
   endtask

   task automatic wait_irq();
      do begin
         @(posedge clk_x);
         #1;
      end while (!irq);
   endtask

   // irq already high when a block is skipped, so poll the bank index
   task automatic wait_bank(input logic bank);
      logic [31:0] rd;
      logic        err;
      do begin
         apb_xfer(1'b0, REG_BANK, 32'h0, rd, err);
      end while (rd[0] !== bank);
   endtask

   // -------------------------------------------------------------------------
   // test sequence
   // -------------------------------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic        err;
      logic [31:0] bc;
      void'($urandom(32'hab22));
      sw_d      = 1'b1;
      strobe_i  = 1'b0;
      sample_i  = '0;
      apb_req   = '0;
      exp_bank  = 1'b0;
      exp_ready = 1'b0;
      exp_ovr   = 1'b0;
      for (int p = 0; p < `CORR_NPAIR; p++) begin
         acc[p]    = 0;
         frozen[p] = 0;
      end
      repeat (8) @(posedge clk_x);
      #1;
      sw_d = 1'b0;

      // reset state
      check_val("irq_o", 32'h0, 32'(irq));
      apb_read(REG_STATUS, "status", 32'h0);
      apb_read(REG_CTRL, "ctrl", 32'h0);
      apb_read(REG_BCOUNT, "bcount", 32'h0);
      apb_read(REG_BANK, "bank", 32'h0);
      check_vis();

      // register access and bus errors
      apb_write(REG_CTRL, 32'h1, 1'b0);
      apb_read(REG_CTRL, "ctrl", 32'h1);
      apb_write(REG_CTRL, 32'h0, 1'b0);
      apb_read(REG_CTRL, "ctrl", 32'h0);
      bc = 32'($urandom % 1024);
      apb_write(REG_BCOUNT, bc, 1'b0);
      apb_read(REG_BCOUNT, "bcount", bc);
      apb_write(REG_STATUS, 32'h3, 1'b1);
      apb_write(REG_VIS2, 32'h5, 1'b1);
      apb_xfer(1'b0, `CORR_ADDR_W'(6'h28), 32'h0, rd, err);   // past last register
      check_val("pslverr", 32'h1, 32'(err));

      // strobes ignored while disabled
      apb_write(REG_BCOUNT, 32'h0, 1'b0);   // one-sample blocks, any counted strobe swaps
      repeat (12) send_strobe(`CORR_NANT'($urandom), 1'b0);
      check_val("irq_o", 32'h0, 32'(irq));
      apb_read(REG_BANK, "bank", 32'h0);
      check_vis();

      // random block lengths read out after each irq
      apb_write(REG_CTRL, 32'h1, 1'b0);
      for (int b = 0; b < 6; b++) begin
         run_block(1 + int'($urandom % 64));
         wait_irq();
         apb_read(REG_BANK, "bank", 32'(exp_bank));
         check_vis();
         check_status();
         apb_read(REG_STATUS, "status", 32'h0);
      end

      // one block skipped by the host
      run_block(1 + int'($urandom % 64));
      wait_irq();
      run_block(1 + int'($urandom % 64));
      wait_bank(exp_bank);
      check_status();                     // ready and overrun both set
      apb_read(REG_STATUS, "status", 32'h0);
      check_vis();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/corr_pkg.sv
hw/corr_bank_switch.sv
hw/corr_xcorr.sv
hw/corr_vis_banks.sv
hw/corr_apb_regs.sv
hw/corr_top.sv
verif/corr_tb.sv
